// ==== hw/rrf_settings.svh ====
// ********************
// Sizing of the renamed-register file.
// Two tiles of RRF_TILE_ENTRIES entries give the physical register count.
// RRF_TILE_ENTRIES and RRF_THREADS must be powers of two.
// ********************

`ifndef RRF_SETTINGS_SVH
`define RRF_SETTINGS_SVH

// Width of one register word in bits.
`define RRF_DATA_WIDTH 32

// Number of read ports, each with its own output enable.
`define RRF_READ_PORTS 4

// Number of write ports. Port 0 wins on a collision.
`define RRF_WRITE_PORTS 2

// Hardware thread contexts held per register.
`define RRF_THREADS 4

// Entries in each of the two tiles.
`define RRF_TILE_ENTRIES 16

`endif

// ==== hw/rrf_addr_pkg.sv ====
// ********************
// Register-address, entry-index and thread-id types.
// The address top bit picks the tile, and the low bits pick the entry.
// ********************

package rrf_addr_pkg;

  `include "rrf_settings.svh"

  localparam int ENTRY_BITS = $clog2(`RRF_TILE_ENTRIES);  // Entry index width.
  localparam int THREAD_BITS = $clog2(`RRF_THREADS);      // Thread id width.

  // Physical register number, tile bit on top.
  typedef logic [ENTRY_BITS:0] rrf_addr_t;

  // Entry index inside one tile.
  typedef logic [ENTRY_BITS-1:0] rrf_entry_t;

  // Hardware thread context.
  typedef logic [THREAD_BITS-1:0] rrf_thread_t;

endpackage

// ==== hw/rrf_data_pkg.sv ====
// ********************
// Register data type.
// The word width follows RRF_DATA_WIDTH.
// ********************

package rrf_data_pkg;

  `include "rrf_settings.svh"

  // One register word as stored and read back.
  typedef logic [`RRF_DATA_WIDTH-1:0] rrf_word_t;

  // All-zero word, driven by a port whose output enable is low.
  localparam rrf_word_t RRF_WORD_ZERO = '0;

  // All-ones word, seen on read_data_n right after reset.
  localparam rrf_word_t RRF_WORD_ONES = '1;

endpackage

// ==== hw/rrf_entry.sv ====
// ********************
// One physical register with one word per thread context.
// write_en must already be qualified by the tile bit.
// Port 0 wins when several write ports hit this entry.
// ********************

`timescale 1ns/1ps

`include "rrf_settings.svh"

module rrf_entry #(
  parameter int ENTRY_INDEX = 0
) (
  input  logic                                               clk,
  input  logic                                               rst,
  input  rrf_addr_pkg::rrf_entry_t [`RRF_WRITE_PORTS-1:0]    write_entry,
  input  rrf_data_pkg::rrf_word_t  [`RRF_WRITE_PORTS-1:0]    write_data,
  input  logic                     [`RRF_WRITE_PORTS-1:0]    write_en,
  input  rrf_addr_pkg::rrf_thread_t                          write_thread,
  input  rrf_addr_pkg::rrf_thread_t                          read_thread,
  output rrf_data_pkg::rrf_word_t                            entry_data
);

  import rrf_addr_pkg::*;
  import rrf_data_pkg::*;

  localparam rrf_entry_t MY_INDEX = rrf_entry_t'(ENTRY_INDEX);  // Entry number in the tile.

  rrf_word_t                    slots [`RRF_THREADS];  // One word per thread.
  logic [`RRF_WRITE_PORTS-1:0]  hit;                   // Ports addressing this entry.
  logic                         any_hit;
  rrf_word_t                    win_data;              // Data of the winning port.

  // ********************
  // Write selection
  // ********************

  always_comb
  begin
    for (int p = 0; p < `RRF_WRITE_PORTS; p++)
    begin
      hit[p] = write_en[p] && (write_entry[p] == MY_INDEX);
    end
  end

  // Walk from the highest port down so that port 0 lands last and wins.
  always_comb
  begin
    any_hit  = 1'b0;
    win_data = RRF_WORD_ZERO;
    for (int p = `RRF_WRITE_PORTS - 1; p >= 0; p--)
    begin
      if (hit[p])
      begin
        any_hit  = 1'b1;
        win_data = write_data[p];
      end
    end
  end

  // ********************
  // Storage
  // ********************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int t = 0; t < `RRF_THREADS; t++)
      begin
        slots[t] <= RRF_WORD_ZERO;  // Every context starts at zero.
      end
    end
    else if (any_hit)
    begin
      slots[write_thread] <= win_data;
    end
  end

  assign entry_data = slots[read_thread];  // Combinational read of one context.

endmodule

// ==== hw/rrf_tile.sv ====
// ********************
// A tile of RRF_TILE_ENTRIES registers.
// Writes whose address top bit differs from TILE_INDEX are ignored.
// Reads are combinational; the caller registers read_entry.
// ********************

`timescale 1ns/1ps

`include "rrf_settings.svh"

module rrf_tile #(
  parameter int TILE_INDEX = 0
) (
  input  logic                                              clk,
  input  logic                                              rst,
  input  rrf_addr_pkg::rrf_entry_t [`RRF_READ_PORTS-1:0]    read_entry,
  input  rrf_addr_pkg::rrf_thread_t                         read_thread,
  output rrf_data_pkg::rrf_word_t  [`RRF_READ_PORTS-1:0]    tile_read_data,
  input  rrf_addr_pkg::rrf_addr_t  [`RRF_WRITE_PORTS-1:0]   write_addr,
  input  rrf_data_pkg::rrf_word_t  [`RRF_WRITE_PORTS-1:0]   write_data,
  input  logic                     [`RRF_WRITE_PORTS-1:0]   write_en,
  input  rrf_addr_pkg::rrf_thread_t                         write_thread
);

  import rrf_addr_pkg::*;
  import rrf_data_pkg::*;

  localparam logic TILE_BIT = TILE_INDEX[0];  // Value of the address top bit for this tile.

  rrf_entry_t [`RRF_WRITE_PORTS-1:0]  write_entry;  // Low address bits per write port.
  logic       [`RRF_WRITE_PORTS-1:0]  tile_wen;     // Enables limited to this tile.
  rrf_word_t                          entry_word [`RRF_TILE_ENTRIES];

  // ********************
  // Write qualification
  // ********************

  genvar p;
  generate
    for (p = 0; p < `RRF_WRITE_PORTS; p++)
    begin : g_wport
      assign write_entry[p] = write_addr[p][ENTRY_BITS-1:0];
      assign tile_wen[p]    = write_en[p] && (write_addr[p][ENTRY_BITS] == TILE_BIT);
    end
  endgenerate

  // ********************
  // Entries
  // ********************

  genvar e;
  generate
    for (e = 0; e < `RRF_TILE_ENTRIES; e++)
    begin : g_entry
      rrf_entry #(
        .ENTRY_INDEX (e)
      ) u_entry (
        .clk          (clk),
        .rst          (rst),
        .write_entry  (write_entry),
        .write_data   (write_data),
        .write_en     (tile_wen),
        .write_thread (write_thread),
        .read_thread  (read_thread),
        .entry_data   (entry_word[e])
      );
    end
  endgenerate

  // ********************
  // Read multiplexers
  // ********************

  // One mux per read port replaces the shared tri-state bus.
  genvar r;
  generate
    for (r = 0; r < `RRF_READ_PORTS; r++)
    begin : g_rport
      assign tile_read_data[r] = entry_word[read_entry[r]];
    end
  endgenerate

endmodule

// ==== hw/rrf.sv ====
// ********************
// Multithreaded renamed-register file, two tiles, 4 read and 2 write ports.
// Read selections are registered under read_clk_en; data follows combinationally.
// A port with its registered output enable low drives zero on both outputs.
// No write-to-read bypass beyond the storage itself.
// ********************

`timescale 1ns/1ps

`include "rrf_settings.svh"

module rrf (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              read_clk_en,
  input  rrf_addr_pkg::rrf_addr_t  [`RRF_READ_PORTS-1:0]    read_addr,
  input  logic                     [`RRF_READ_PORTS-1:0]    read_oe,
  input  rrf_addr_pkg::rrf_thread_t                         read_thread,
  output rrf_data_pkg::rrf_word_t  [`RRF_READ_PORTS-1:0]    read_data,
  output rrf_data_pkg::rrf_word_t  [`RRF_READ_PORTS-1:0]    read_data_n,
  input  rrf_addr_pkg::rrf_addr_t  [`RRF_WRITE_PORTS-1:0]   write_addr,
  input  rrf_data_pkg::rrf_word_t  [`RRF_WRITE_PORTS-1:0]   write_data,
  input  logic                     [`RRF_WRITE_PORTS-1:0]   write_en,
  input  rrf_addr_pkg::rrf_thread_t                         write_thread
);

  import rrf_addr_pkg::*;
  import rrf_data_pkg::*;

  localparam int TILES = 1 << ($bits(rrf_addr_t) - $bits(rrf_entry_t));  // Two tiles.

  rrf_addr_t  [`RRF_READ_PORTS-1:0]  read_addr_q;    // Registered read addresses.
  logic       [`RRF_READ_PORTS-1:0]  read_oe_q;      // Registered output enables.
  rrf_thread_t                       read_thread_q;  // Registered read thread.
  rrf_entry_t [`RRF_READ_PORTS-1:0]  read_entry_q;   // Entry part of each address.
  rrf_word_t  [`RRF_READ_PORTS-1:0]  tile_read_data [TILES];
  rrf_word_t  [`RRF_READ_PORTS-1:0]  sel_word;       // Word from the addressed tile.

  // ********************
  // Read selection register
  // ********************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_addr_q   <= '0;
      read_oe_q     <= '1;  // Ports come out of reset enabled.
      read_thread_q <= '0;
    end
    else if (read_clk_en)
    begin
      read_addr_q   <= read_addr;
      read_oe_q     <= read_oe;
      read_thread_q <= read_thread;
    end
  end

  genvar p;
  generate
    for (p = 0; p < `RRF_READ_PORTS; p++)
    begin : g_entry_idx
      assign read_entry_q[p] = read_addr_q[p][ENTRY_BITS-1:0];
    end
  endgenerate

  // ********************
  // Tiles
  // ********************

  genvar t;
  generate
    for (t = 0; t < TILES; t++)
    begin : g_tile
      rrf_tile #(
        .TILE_INDEX (t)
      ) u_tile (
        .clk            (clk),
        .rst            (rst),
        .read_entry     (read_entry_q),
        .read_thread    (read_thread_q),
        .tile_read_data (tile_read_data[t]),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .write_en       (write_en),
        .write_thread   (write_thread)
      );
    end
  endgenerate

  // ********************
  // Output stage
  // ********************

  genvar r;
  generate
    for (r = 0; r < `RRF_READ_PORTS; r++)
    begin : g_out
      // The address top bit steers between the two tiles.
      assign sel_word[r] = tile_read_data[read_addr_q[r][ENTRY_BITS]][r];

      assign read_data[r]   = read_oe_q[r] ? sel_word[r] : RRF_WORD_ZERO;
      assign read_data_n[r] = read_oe_q[r] ? ~sel_word[r] : RRF_WORD_ZERO;
    end
  endgenerate

endmodule

// ==== testbench/rrf_assert.sv ====
// ********************
// Output rules of rrf, checked at each rising edge outside reset.
// Bound into rrf and reads its registered output enables.
// ********************

`timescale 1ns/1ps

`include "rrf_settings.svh"

module rrf_assert (
  input logic                                             clk,
  input logic                                             rst,
  input logic                    [`RRF_READ_PORTS-1:0]    read_oe_q,
  input rrf_data_pkg::rrf_word_t [`RRF_READ_PORTS-1:0]    read_data,
  input rrf_data_pkg::rrf_word_t [`RRF_READ_PORTS-1:0]    read_data_n
);

  import rrf_data_pkg::*;

  genvar p;
  generate
    for (p = 0; p < `RRF_READ_PORTS; p++)
    begin : g_port
      a_inverse: assert property (@(posedge clk) disable iff (rst)
        read_oe_q[p] |-> (read_data_n[p] == ~read_data[p]))
        else $error("Port %0d drives read_data_n that is not the inverse of read_data", p);

      // A disabled port is quiet on both outputs.
      a_off_zero: assert property (@(posedge clk) disable iff (rst)
        !read_oe_q[p] |-> (read_data[p] == RRF_WORD_ZERO && read_data_n[p] == RRF_WORD_ZERO))
        else $error("Port %0d is disabled but drives a nonzero output", p);
    end
  endgenerate

  a_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({read_data, read_data_n}))
    else $error("Read outputs hold unknown bits after reset");

endmodule

bind rrf rrf_assert u_rrf_assert (
  .clk         (clk),
  .rst         (rst),
  .read_oe_q   (read_oe_q),
  .read_data   (read_data),
  .read_data_n (read_data_n)
);

// ==== testbench/rrf_tb.sv ====
// ********************
// Table-driven testbench for rrf. Each table row is one test.
// Expected words come from a model indexed by thread and register.
// Inputs change on the falling edge of clk.
// ********************

`timescale 1ns/1ps

`include "rrf_settings.svh"

module rrf_tb;

  import rrf_addr_pkg::*;
  import rrf_data_pkg::*;

  localparam logic [1:0] K_WRITE   = 2'd0;  // Pairs of writes, one pair per cycle.
  localparam logic [1:0] K_READ    = 2'd1;  // Four ports read a stride of 8 registers.
  localparam logic [1:0] K_HOLD    = 2'd2;
  localparam logic [1:0] K_COLLIDE = 2'd3;
  localparam logic       R_MODEL   = 1'b0;  // Expect the model word.
  localparam logic       R_RESET   = 1'b1;  // Expect zero data and all-ones inverse.

  typedef struct packed {
    logic [1:0]                  kind;
    rrf_thread_t                 thread;
    rrf_addr_t                   addr;   // First register touched.
    logic [7:0]                  count;  // Cycles for writes and reads.
    logic [`RRF_READ_PORTS-1:0]  oe;
    logic [7:0]                  seed;   // Index into the data pool.
    logic                        tag;
  } step_t;

  logic                                clk;
  logic                                rst;
  logic                                read_clk_en;
  rrf_addr_t  [`RRF_READ_PORTS-1:0]    read_addr;
  logic       [`RRF_READ_PORTS-1:0]    read_oe;
  rrf_thread_t                         read_thread;
  rrf_word_t  [`RRF_READ_PORTS-1:0]    read_data;
  rrf_word_t  [`RRF_READ_PORTS-1:0]    read_data_n;
  rrf_addr_t  [`RRF_WRITE_PORTS-1:0]   write_addr;
  rrf_word_t  [`RRF_WRITE_PORTS-1:0]   write_data;
  logic       [`RRF_WRITE_PORTS-1:0]   write_en;
  rrf_thread_t                         write_thread;

  step_t                       steps [$];
  rrf_word_t                   pool [256];
  rrf_word_t                   model [`RRF_THREADS][2*`RRF_TILE_ENTRIES];
  rrf_addr_t                   sel_addr [`RRF_READ_PORTS];  // Selection the DUT holds.
  logic [`RRF_READ_PORTS-1:0]  sel_oe;
  rrf_thread_t                 sel_thread;
  int                          checks;
  int                          errors;
  bit                          table_ready;

  rrf uut (
    .clk          (clk),
    .rst          (rst),
    .read_clk_en  (read_clk_en),
    .read_addr    (read_addr),
    .read_oe      (read_oe),
    .read_thread  (read_thread),
    .read_data    (read_data),
    .read_data_n  (read_data_n),
    .write_addr   (write_addr),
    .write_data   (write_data),
    .write_en     (write_en),
    .write_thread (write_thread)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int step_cycles(input step_t s);
    if (s.kind == K_HOLD || s.kind == K_COLLIDE)
      return 3;
    return int'(s.count);
  endfunction

  function automatic string kind_name(input logic [1:0] kind);
    case (kind)
      K_WRITE: return "write";
      K_READ:  return "read";
      K_HOLD:  return "hold";
      default: return "collide";
    endcase
  endfunction

  task automatic add_step(input logic [1:0] kind, input int thread, input int addr,
                          input int count, input logic [3:0] oe, input int seed,
                          input logic tag);
    step_t s;
    s.kind   = kind;
    s.thread = rrf_thread_t'(thread);
    s.addr   = rrf_addr_t'(addr);
    s.count  = 8'(count);
    s.oe     = oe;
    s.seed   = 8'(seed);
    s.tag    = tag;
    steps.push_back(s);
  endtask

  // ********************
  // Stimulus table
  // ********************

  task automatic build_table();
    add_step(K_READ, 0, 0, 1, 4'hf, 0, R_RESET);  // State right after reset.
    for (int t = 0; t < `RRF_THREADS; t++)
    begin
      add_step(K_WRITE, t, 0, 16, 4'hf, 32 * t, R_MODEL);  // Fill all 32 registers.
    end
    for (int t = 0; t < `RRF_THREADS; t++)
    begin
      add_step(K_READ, t, 0, 8, 4'hf, 0, R_MODEL);
    end
    add_step(K_COLLIDE, 2, 9, 0, 4'hf, 128, R_MODEL);
    add_step(K_HOLD, 1, 20, 0, 4'hf, 132, R_MODEL);
    add_step(K_READ, 3, 4, 2, 4'b0101, 0, R_MODEL);  // Ports 1 and 3 switched off.
    add_step(K_READ, 0, 30, 1, 4'b0000, 0, R_MODEL);
    add_step(K_WRITE, 1, 5, 1, 4'hf, 140, R_MODEL);  // Thread 1 only.
    for (int t = 0; t < `RRF_THREADS; t++)
    begin
      add_step(K_READ, t, 5, 1, 4'hf, 0, R_MODEL);
    end
  endtask

  // ********************
  // Drivers and checks
  // ********************

  task automatic select_ports(input rrf_addr_t base, input rrf_thread_t thr,
                              input logic [`RRF_READ_PORTS-1:0] oe);
    for (int p = 0; p < `RRF_READ_PORTS; p++)
    begin
      read_addr[p] = base + rrf_addr_t'(8 * p);  // Ports spread over both tiles.
      sel_addr[p]  = read_addr[p];
    end
    read_oe     = oe;
    read_thread = thr;
    read_clk_en = 1'b1;
    sel_oe      = oe;
    sel_thread  = thr;
  endtask

  task automatic write_pair(input rrf_addr_t a0, input rrf_addr_t a1, input rrf_word_t d0,
                            input rrf_word_t d1, input rrf_thread_t thr);
    write_addr[0] = a0;
    write_addr[1] = a1;
    write_data[0] = d0;
    write_data[1] = d1;
    write_en      = 2'b11;
    write_thread  = thr;
    model[thr][a1] = d1;
    model[thr][a0] = d0;  // Port 0 overrides on a collision.
    @(negedge clk);
    write_en = '0;
  endtask

  task automatic check_ports(input logic tag);
    rrf_word_t exp;
    rrf_word_t exp_n;
    for (int p = 0; p < `RRF_READ_PORTS; p++)
    begin
      if (tag == R_RESET)
      begin
        exp   = '0;
        exp_n = RRF_WORD_ONES;
      end
      else
      begin
        exp   = sel_oe[p] ? model[sel_thread][sel_addr[p]] : '0;
        exp_n = sel_oe[p] ? ~exp : '0;
      end
      checks++;
      if (read_data[p] !== exp || read_data_n[p] !== exp_n)
      begin
        errors++;
        $display("Error at %0t ns: port %0d reg %0d thread %0d read %h/%h, expected %h/%h",
                 $time, p, sel_addr[p], sel_thread, read_data[p], read_data_n[p],
                 exp, exp_n);
      end
    end
  endtask

  task automatic run_step(input step_t s);
    rrf_addr_t a;
    case (s.kind)
      K_WRITE:
        for (int i = 0; i < int'(s.count); i++)
        begin
          a = s.addr + rrf_addr_t'(2 * i);
          write_pair(a, a + 1'b1, pool[8'(int'(s.seed) + 2 * i)],
                     pool[8'(int'(s.seed) + 2 * i + 1)], s.thread);
        end
      K_READ:
        if (s.tag == R_RESET)
          check_ports(R_RESET);
        else
          for (int i = 0; i < int'(s.count); i++)
          begin
            select_ports(s.addr + rrf_addr_t'(i), s.thread, s.oe);
            @(negedge clk);
            read_clk_en = 1'b0;
            check_ports(R_MODEL);
          end
      K_HOLD:
      begin
        select_ports(s.addr, s.thread, s.oe);
        @(negedge clk);
        check_ports(R_MODEL);
        read_clk_en = 1'b0;  // New inputs must not reach the outputs.
        for (int p = 0; p < `RRF_READ_PORTS; p++)
        begin
          read_addr[p] = read_addr[p] + 5'd3;
        end
        read_thread = rrf_thread_t'(s.thread + 1'b1);
        @(negedge clk);
        check_ports(R_MODEL);
        write_pair(s.addr, s.addr + 1'b1, pool[s.seed], pool[s.seed + 1'b1], s.thread);
        check_ports(R_MODEL);
      end
      default:
      begin
        write_pair(s.addr, s.addr, pool[s.seed], pool[s.seed + 8'd1], s.thread);
        write_pair(s.addr + 5'd8, s.addr + 5'd16, pool[s.seed + 8'd2], pool[s.seed + 8'd3],
                   s.thread);
        select_ports(s.addr, s.thread, s.oe);
        @(negedge clk);
        read_clk_en = 1'b0;
        check_ports(R_MODEL);
      end
    endcase
  endtask

  // ********************
  // Main sequence
  // ********************

  initial
  begin
    logic [31:0] x;
    int          checks_before;
    int          errors_before;
    rst          = 1'b1;
    read_clk_en  = 1'b0;
    read_addr    = '0;
    read_oe      = '1;
    read_thread  = '0;
    write_addr   = '0;
    write_data   = '0;
    write_en     = '0;
    write_thread = '0;
    sel_oe       = '1;
    sel_thread   = '0;
    checks       = 0;
    errors       = 0;
    for (int p = 0; p < `RRF_READ_PORTS; p++)
    begin
      sel_addr[p] = '0;
    end
    x = 32'hba28;
    for (int i = 0; i < 256; i++)
    begin
      x       = xorshift32(x);
      pool[i] = x;
    end
    for (int t = 0; t < `RRF_THREADS; t++)
    begin
      for (int a = 0; a < 2 * `RRF_TILE_ENTRIES; a++)
      begin
        model[t][a] = '0;  // Storage clears on reset.
      end
    end
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < steps.size(); i++)
    begin
      checks_before = checks;
      errors_before = errors;
      run_step(steps[i]);
      $display("Test %0d (%s): %0d checks, %0d errors", i, kind_name(steps[i].kind),
               checks - checks_before, errors - errors_before);
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", steps.size(), checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // Run limit follows the cycle count of the table, with a wide margin.
  initial
  begin
    int cycles;
    wait (table_ready);
    cycles = 5;
    foreach (steps[i])
    begin
      cycles += step_cycles(steps[i]);
    end
    #(cycles * 4 * 10 + 200);
    $display("Watchdog expired: the tests did not finish within %0d cycles.", cycles * 4);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/rrf_addr_pkg.sv
hw/rrf_data_pkg.sv
hw/rrf_entry.sv
hw/rrf_tile.sv
hw/rrf.sv
testbench/rrf_assert.sv
testbench/rrf_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the rrf testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rrf_tb \
  -f files.f -o sim_rrf > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/sim_rrf > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation passed"
exit 0
